// File: hw/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// ifmap row length in pixels
`define CONV_ROW_LEN 36

// kernel side, window is CONV_K x CONV_K
`define CONV_K 3

// signed data widths
`define CONV_PIX_W 8
`define CONV_WGT_W 8

// ofmap width, holds nine full-scale products
`define CONV_ACC_W 20

`endif

// File: hw/conv_fmap_pkg.sv
`include "conv_cfg.svh"

package conv_fmap_pkg;

    // one ifmap pixel
    typedef logic signed [`CONV_PIX_W-1:0] pixel_t;

    // px[row][col], row 0 oldest, col 0 leftmost
    typedef struct packed {
        pixel_t [`CONV_K-1:0][`CONV_K-1:0] px;
    } window_t;

    // pixel times weight
    typedef logic signed [`CONV_PIX_W+`CONV_WGT_W-1:0] product_t;

    // p[row][col], same layout as the window
    typedef struct packed {
        product_t [`CONV_K-1:0][`CONV_K-1:0] p;
    } product_set_t;

    // reduced output value
    typedef logic signed [`CONV_ACC_W-1:0] ofmap_t;

endpackage

// File: hw/conv_kernel_pkg.sv
`include "conv_cfg.svh"

package conv_kernel_pkg;

    // one kernel weight
    typedef logic signed [`CONV_WGT_W-1:0] weight_t;

    // w[row][col], indexed like the ifmap window
    typedef struct packed {
        weight_t [`CONV_K-1:0][`CONV_K-1:0] w;
    } kernel_t;

endpackage

// File: hw/line_buffer.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module line_buffer
    import conv_fmap_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    frame_start,
    input  logic    pixel_valid,
    input  pixel_t  pixel_in,
    output window_t win,
    output logic    win_valid
);

    localparam int ROW_LEN = `CONV_ROW_LEN;
    localparam int K       = `CONV_K;
    localparam int COL_W   = $clog2(ROW_LEN);

    // index 0 is the oldest entry
    pixel_t [ROW_LEN-1:0] row_buf1;
    pixel_t [ROW_LEN-1:0] row_buf2;

    logic [COL_W-1:0] col_cnt;
    logic [1:0]       row_cnt;
    logic             at_window;

    // position of the pixel being accepted
    assign at_window = (row_cnt == 2'(K - 1)) && (col_cnt >= COL_W'(K - 1));

    // two chained rows, row_buf2 is fed from the tail of row_buf1
    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            row_buf1 <= {pixel_in, row_buf1[ROW_LEN-1:1]};
            row_buf2 <= {row_buf1[0], row_buf2[ROW_LEN-1:1]};
        end
    end

    // window slides left by one column per pixel
    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            for (int i = 0; i < K; i++) begin
                for (int j = 0; j < K - 1; j++) begin
                    win.px[i][j] <= win.px[i][j+1];
                end
            end
            // taps hold the same column from one and two rows back
            win.px[0][K-1] <= row_buf2[0];
            win.px[1][K-1] <= row_buf1[0];
            win.px[2][K-1] <= pixel_in;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            win_valid <= 1'b0;
        end else begin
            win_valid <= pixel_valid && at_window;
            if (frame_start) begin
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (pixel_valid) begin
                if (col_cnt == COL_W'(ROW_LEN - 1)) begin
                    col_cnt <= '0;
                    // saturate, only rows 2 and up matter
                    if (row_cnt != 2'(K - 1)) begin
                        row_cnt <= row_cnt + 2'd1;
                    end
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    a_frame_start_alone: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(frame_start && pixel_valid)
    ) else $error("frame_start seen together with pixel_valid");

    a_col_in_row: assert property (
        @(posedge clk) disable iff (!arst_n)
        col_cnt < COL_W'(ROW_LEN)
    ) else $error("column count past row length: %0d", col_cnt);

endmodule

// File: hw/pe_mult.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module pe_mult
    import conv_fmap_pkg::*;
    import conv_kernel_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         weight_en,
    input  kernel_t      kernel_in,
    input  window_t      win,
    input  logic         win_valid,
    output product_set_t prod,
    output logic         prod_valid
);

    localparam int K = `CONV_K;

    kernel_t kern_q;

    always_ff @(posedge clk) begin
        if (weight_en) begin
            kern_q <= kernel_in;
        end
    end

    // nine signed multiplies, only on a valid window
    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int i = 0; i < K; i++) begin
                for (int j = 0; j < K; j++) begin
                    prod.p[i][j] <= product_t'($signed(win.px[i][j]))
                                  * product_t'($signed(kern_q.w[i][j]));
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= win_valid;
        end
    end

    // kernel must be settled before windows reach this stage
    a_no_reload_in_flight: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(weight_en && win_valid)
    ) else $error("kernel reloaded while a window is in flight");

endmodule

// File: hw/sum_tree.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module sum_tree
    import conv_fmap_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  product_set_t prod,
    input  logic         prod_valid,
    output ofmap_t       ofmap_out,
    output logic         ofmap_valid
);

    localparam int K = `CONV_K;
    localparam int N = K * K;

    ofmap_t ext [N];
    ofmap_t lvl1 [4];
    ofmap_t lvl2 [2];
    ofmap_t total;

    always_comb begin
        for (int i = 0; i < K; i++) begin
            for (int j = 0; j < K; j++) begin
                ext[i*K+j] = ofmap_t'(prod.p[i][j]);
            end
        end
    end

    // pairs first, last product joins at the top
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            lvl1[k] = ext[2*k] + ext[2*k+1];
        end
        lvl2[0] = lvl1[0] + lvl1[1];
        lvl2[1] = lvl1[2] + lvl1[3];
        total   = (lvl2[0] + lvl2[1]) + ext[N-1];
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            ofmap_out <= total;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ofmap_valid <= 1'b0;
        end else begin
            ofmap_valid <= prod_valid;
        end
    end

    a_ofmap_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        ofmap_valid |-> !$isunknown(ofmap_out)
    ) else $error("ofmap_out has unknown bits while valid");

endmodule

// File: hw/conv_top.sv
`timescale 1ns/1ps

module conv_top
    import conv_fmap_pkg::*;
    import conv_kernel_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    frame_start,
    input  logic    pixel_valid,
    input  pixel_t  pixel_in,
    input  logic    weight_en,
    input  kernel_t kernel_in,
    output ofmap_t  ofmap_out,
    output logic    ofmap_valid
);

    window_t      win;
    logic         win_valid;
    product_set_t prod;
    logic         prod_valid;

    // window forming, one edge after the accepted pixel
    line_buffer u_line_buffer (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_start (frame_start),
        .pixel_valid (pixel_valid),
        .pixel_in    (pixel_in),
        .win         (win),
        .win_valid   (win_valid)
    );

    pe_mult u_pe_mult (
        .clk        (clk),
        .arst_n     (arst_n),
        .weight_en  (weight_en),
        .kernel_in  (kernel_in),
        .win        (win),
        .win_valid  (win_valid),
        .prod       (prod),
        .prod_valid (prod_valid)
    );

    // result lands three edges after the completing pixel
    sum_tree u_sum_tree (
        .clk         (clk),
        .arst_n      (arst_n),
        .prod        (prod),
        .prod_valid  (prod_valid),
        .ofmap_out   (ofmap_out),
        .ofmap_valid (ofmap_valid)
    );

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: tb/tb_conv_top.sv
`timescale 1ns/1ps
`include "conv_cfg.svh"

module tb_conv_top
    import conv_fmap_pkg::*;
    import conv_kernel_pkg::*;
();

    localparam int ROW_LEN         = `CONV_ROW_LEN;
    localparam int K               = `CONV_K;
    localparam int WGT_W           = `CONV_WGT_W;
    localparam int ROWS            = 6;
    localparam int FRAME_PIX       = ROWS * ROW_LEN;
    localparam int FRAME_RESULTS   = (ROWS - K + 1) * (ROW_LEN - K + 1);
    localparam int NUM_FRAMES      = 4;
    localparam int CLK_PERIOD_NS   = 100;
    // gap frame may take up to twice its pixel count
    localparam int WATCHDOG_CYCLES = FRAME_PIX * (NUM_FRAMES + 1) + NUM_FRAMES * 16 + 50;
    localparam ofmap_t FULL_SCALE  = ofmap_t'(147456);

    typedef struct packed {
        int     due;
        ofmap_t value;
    } expect_t;

    logic    clk;
    logic    arst_n;
    logic    frame_start;
    logic    pixel_valid;
    pixel_t  pixel_in;
    logic    weight_en;
    kernel_t kernel_in;
    ofmap_t  ofmap_out;
    logic    ofmap_valid;

    expect_t exp_q[$];
    expect_t exp_entry;
    pixel_t  frame_px[$];
    kernel_t kern_ref;
    int      edge_idx = 0;
    int      row_pos = 0;
    int      col_pos = 0;
    int      pulse_cnt = 0;
    int      pending = 0;
    logic    exp_valid = 1'b0;
    ofmap_t  exp_value = '0;
    logic    full_scale_on;
    integer  seed = 32'h2481_aea2;

    int value_err_cnt = 0;
    int full_scale_err_cnt = 0;
    int missing_cnt = 0;
    int extra_cnt = 0;
    int count_err_cnt = 0;
    int total_err;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk_gen (.clk(clk));

    conv_top uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_start (frame_start),
        .pixel_valid (pixel_valid),
        .pixel_in    (pixel_in),
        .weight_en   (weight_en),
        .kernel_in   (kernel_in),
        .ofmap_out   (ofmap_out),
        .ofmap_valid (ofmap_valid)
    );

    // w[i][j] sits at bit offset (i*K + j) * WGT_W
    function automatic int weight_at(kernel_t k, int i, int j);
        logic [K*K*WGT_W-1:0] flat;
        flat = k;
        return int'(weight_t'(flat >> (WGT_W * (i * K + j))));
    endfunction

    function automatic int window_sum(int row, int col);
        int sum;
        int idx;
        sum = 0;
        for (int i = 0; i < K; i++) begin
            for (int j = 0; j < K; j++) begin
                idx = (row - (K - 1) + i) * ROW_LEN + (col - (K - 1) + j);
                sum += int'(frame_px[idx]) * weight_at(kern_ref, i, j);
            end
        end
        return sum;
    endfunction

    // reference model on the DUT's sampling edges
    always @(posedge clk) begin
        edge_idx++;
        if (!arst_n) begin
            exp_q.delete();
            frame_px.delete();
            row_pos   = 0;
            col_pos   = 0;
            pulse_cnt = 0;
        end else begin
            if (ofmap_valid) begin
                pulse_cnt++;
            end
            if (exp_q.size() > 0) begin
                if (exp_q[0].due == edge_idx) begin
                    void'(exp_q.pop_front());
                end
            end
            if (weight_en) begin
                kern_ref = kernel_in;
            end
            if (frame_start) begin
                frame_px.delete();
                row_pos   = 0;
                col_pos   = 0;
                pulse_cnt = 0;
            end else if (pixel_valid) begin
                frame_px.push_back(pixel_in);
                if (row_pos >= K - 1 && col_pos >= K - 1) begin
                    exp_entry.due   = edge_idx + 3;
                    exp_entry.value = ofmap_t'(window_sum(row_pos, col_pos));
                    exp_q.push_back(exp_entry);
                end
                if (col_pos == ROW_LEN - 1) begin
                    col_pos = 0;
                    row_pos++;
                end else begin
                    col_pos++;
                end
            end
        end
        // what the next edge should see
        exp_valid <= 1'b0;
        if (exp_q.size() > 0) begin
            if (exp_q[0].due == edge_idx + 1) begin
                exp_valid <= 1'b1;
            end
            exp_value <= exp_q[0].value;
        end
        pending <= exp_q.size();
    end

    a_no_extra: assert property (
        @(posedge clk) disable iff (!arst_n)
        ofmap_valid |-> exp_valid
    ) else begin
        $display("%0t: ofmap_valid high with no result due", $time);
        extra_cnt++;
    end

    a_no_missing: assert property (
        @(posedge clk) disable iff (!arst_n)
        exp_valid |-> ofmap_valid
    ) else begin
        $display("%0t: expected result missing, ofmap_valid low", $time);
        missing_cnt++;
    end

    a_value: assert property (
        @(posedge clk) disable iff (!arst_n)
        (exp_valid && ofmap_valid) |-> (ofmap_out == exp_value)
    ) else begin
        $display("MISMATCH at %0t: ofmap_out expected %0d, got %0d",
                 $time, $sampled(exp_value), $sampled(ofmap_out));
        value_err_cnt++;
    end

    // all -128 inputs, nine full-scale products
    a_full_scale: assert property (
        @(posedge clk) disable iff (!arst_n)
        (ofmap_valid && full_scale_on) |-> (ofmap_out == FULL_SCALE)
    ) else begin
        $display("MISMATCH at %0t: ofmap_out expected %0d, got %0d",
                 $time, FULL_SCALE, $sampled(ofmap_out));
        full_scale_err_cnt++;
    end

    task automatic drive_idle();
        @(posedge clk);
        #1;
        frame_start = 1'b0;
        pixel_valid = 1'b0;
        weight_en   = 1'b0;
    endtask

    task automatic start_frame();
        @(posedge clk);
        #1;
        frame_start = 1'b1;
        pixel_valid = 1'b0;
        weight_en   = 1'b0;
    endtask

    task automatic load_kernel(input kernel_t k);
        @(posedge clk);
        #1;
        frame_start = 1'b0;
        pixel_valid = 1'b0;
        weight_en   = 1'b1;
        kernel_in   = k;
    endtask

    task automatic send_pixel(input pixel_t p);
        @(posedge clk);
        #1;
        frame_start = 1'b0;
        weight_en   = 1'b0;
        pixel_valid = 1'b1;
        pixel_in    = p;
    endtask

    // bounded by the watchdog
    task automatic wait_drain();
        while (pending != 0) begin
            drive_idle();
        end
        drive_idle();
    endtask

    task automatic check_result_count(input int frame_no);
        assert (pulse_cnt == FRAME_RESULTS) else begin
            $display("frame %0d gave %0d results instead of %0d",
                     frame_no, pulse_cnt, FRAME_RESULTS);
            count_err_cnt++;
        end
    endtask

    task automatic run_frame(input int frame_no, input bit with_gaps, input bit full_scale);
        kernel_t     k;
        pixel_t      p;
        logic [95:0] rnd;
        rnd = {$random(seed), $random(seed), $random(seed)};
        k = full_scale ? kernel_t'({(K * K){8'h80}}) : kernel_t'(rnd[K*K*WGT_W-1:0]);
        start_frame();
        load_kernel(k);
        for (int n = 0; n < FRAME_PIX; n++) begin
            if (with_gaps && (($random(seed) & 3) == 0)) begin
                drive_idle();
            end
            p = full_scale ? pixel_t'(-128) : pixel_t'($random(seed));
            send_pixel(p);
        end
        drive_idle();
        wait_drain();
        check_result_count(frame_no);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("timeout after %0d cycles, pipeline did not finish", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        arst_n        = 1'b0;
        frame_start   = 1'b0;
        pixel_valid   = 1'b0;
        pixel_in      = '0;
        weight_en     = 1'b0;
        kernel_in     = '0;
        full_scale_on = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        drive_idle();
        drive_idle();

        run_frame(0, 1'b0, 1'b0);
        run_frame(1, 1'b0, 1'b0);
        run_frame(2, 1'b1, 1'b0);
        full_scale_on = 1'b1;
        run_frame(3, 1'b0, 1'b1);

        total_err = value_err_cnt + full_scale_err_cnt + missing_cnt + extra_cnt
                  + count_err_cnt;
        $display("errors: %0d (value %0d, full scale %0d, missing %0d, extra %0d, count %0d)",
                 total_err, value_err_cnt, full_scale_err_cnt, missing_cnt, extra_cnt,
                 count_err_cnt);
        if (total_err == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+hw
hw/conv_fmap_pkg.sv
hw/conv_kernel_pkg.sv
hw/line_buffer.sv
hw/pe_mult.sv
hw/sum_tree.sv
hw/conv_top.sv
tb/tb_clk_gen.sv
tb/tb_conv_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_conv_top -o vsim -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/vsim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
